//--- verilog/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

    localparam int FRAME_BITS  = 11;      // Start, 8 data, parity, stop
    localparam logic [7:0] BREAK_CODE = 8'hF0;  // Release prefix
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = 3;
    localparam int EVENT_W     = 17;      // {release, code, ascii}

    // Set 2 scan code to upper case ASCII for letters and digits only
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        logic [7:0] ascii;
        case (code)
            8'h1C: ascii = 8'h41;  // A
            8'h32: ascii = 8'h42;
            8'h21: ascii = 8'h43;
            8'h23: ascii = 8'h44;
            8'h24: ascii = 8'h45;
            8'h2B: ascii = 8'h46;
            8'h34: ascii = 8'h47;
            8'h33: ascii = 8'h48;
            8'h43: ascii = 8'h49;
            8'h3B: ascii = 8'h4A;
            8'h42: ascii = 8'h4B;
            8'h4B: ascii = 8'h4C;
            8'h3A: ascii = 8'h4D;
            8'h31: ascii = 8'h4E;
            8'h44: ascii = 8'h4F;
            8'h4D: ascii = 8'h50;
            8'h15: ascii = 8'h51;
            8'h2D: ascii = 8'h52;
            8'h1B: ascii = 8'h53;
            8'h2C: ascii = 8'h54;
            8'h3C: ascii = 8'h55;
            8'h2A: ascii = 8'h56;
            8'h1D: ascii = 8'h57;
            8'h22: ascii = 8'h58;
            8'h35: ascii = 8'h59;
            8'h1A: ascii = 8'h5A;  // Z
            8'h45: ascii = 8'h30;  // 0
            8'h16: ascii = 8'h31;
            8'h1E: ascii = 8'h32;
            8'h26: ascii = 8'h33;
            8'h25: ascii = 8'h34;
            8'h2E: ascii = 8'h35;
            8'h36: ascii = 8'h36;
            8'h3D: ascii = 8'h37;
            8'h3E: ascii = 8'h38;
            8'h46: ascii = 8'h39;  // 9
            default: ascii = 8'h00;  // Unmapped
        endcase
        return ascii;
    endfunction

endpackage

`default_nettype wire

//--- verilog/ps2_rx.sv
`default_nettype none

module ps2_rx import kbd_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_data,
    output logic            byte_valid,
    output logic [7:0]      byte_data,
    output logic            frame_error
);

    logic [1:0] clk_sync;      // Two-flop synchronizer for ps2_clk
    logic [1:0] data_sync;     // Same for ps2_data
    logic       clk_prev;      // Delayed copy for edge detect
    logic       fall;          // Synchronized ps2_clk falling edge
    logic       last_bit;

    logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
    logic [FRAME_BITS-2:0]         shreg;   // First ten bits with the start bit at bit 0
    logic [FRAME_BITS-1:0]         frame;   // Complete frame on the last edge
    logic                          frame_ok;

    // Lines idle high, so the synchronizer starts from ones
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall     = clk_prev & ~clk_sync[1];
    assign last_bit = (bit_cnt == FRAME_BITS - 1);

    // Stop bit is still on the line when the last edge arrives
    assign frame = {data_sync[1], shreg};

    assign frame_ok = ~frame[0]                   // Start bit low
                    & frame[FRAME_BITS-1]         // Stop bit high
                    & (^frame[FRAME_BITS-2:1]);   // Odd parity over data and parity

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt     <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (fall) begin
                if (last_bit) begin
                    bit_cnt <= '0;
                    if (frame_ok)
                        byte_valid <= 1'b1;
                    else
                        frame_error <= 1'b1;  // Sticky until reset
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall)
            shreg <= {data_sync[1], shreg[FRAME_BITS-2:1]};
        if (fall && last_bit && frame_ok)
            byte_data <= frame[8:1];  // Data bits only
    end

endmodule

`default_nettype wire

//--- verilog/key_decoder.sv
`default_nettype none

module key_decoder import kbd_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               byte_valid,
    input  wire logic [7:0]         byte_data,
    output logic                    ev_valid,
    output logic [EVENT_W-1:0]      ev_data,
    output logic [7:0]              press_count
);

    logic break_pending;   // F0 seen, next code is a release
    logic is_prefix;
    logic take_code;       // Byte that turns into an event
    logic [7:0] ascii;

    assign is_prefix = (byte_data == BREAK_CODE);
    assign take_code = byte_valid & ~is_prefix;
    assign ascii     = scan_to_ascii(byte_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            break_pending <= 1'b0;
        end else if (byte_valid) begin
            // A code after the prefix consumes it
            break_pending <= is_prefix;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            ev_valid <= 1'b0;
        else
            ev_valid <= take_code;  // One cycle strobe
    end

    // Releases are not counted
    always_ff @(posedge clk) begin
        if (reset)
            press_count <= 8'd0;
        else if (take_code && !break_pending)
            press_count <= press_count + 8'd1;  // Wraps at 256
    end

    always_ff @(posedge clk) begin
        if (take_code)
            ev_data <= {break_pending, byte_data, ascii};
    end

endmodule

`default_nettype wire

//--- verilog/event_queue.sv
`default_nettype none

module event_queue import kbd_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               push,
    input  wire logic [EVENT_W-1:0] push_data,
    input  wire logic               pop,
    output logic                    ready,
    output logic [EVENT_W-1:0]      head,
    output logic                    overflow
);

    logic [EVENT_W-1:0]     mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   occupancy;   // Entries held from 0 to QUEUE_DEPTH
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full    = (occupancy == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
    assign ready   = (occupancy != '0);
    assign do_pop  = pop & ready;          // Pop on empty is ignored
    assign do_push = push & (~full | do_pop);
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            overflow  <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps with depth a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                occupancy <= occupancy + 1'b1;
            else if (do_pop && !do_push)
                occupancy <= occupancy - 1'b1;
            if (push && !do_push)
                overflow <= 1'b1;  // Dropped event
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

//--- verilog/keyboard_top.sv
`default_nettype none

module keyboard_top import kbd_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_data,
    input  wire logic       key_read,
    output logic            key_ready,
    output logic [7:0]      key_code,
    output logic [7:0]      key_ascii,
    output logic            key_release,
    output logic [7:0]      press_count,
    output logic            overflow,
    output logic            frame_error
);

    logic               byte_valid;
    logic [7:0]         byte_data;
    logic               ev_valid;
    logic [EVENT_W-1:0] ev_data;
    logic [EVENT_W-1:0] head;

    ps2_rx u_ps2_rx (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_error (frame_error)
    );

    key_decoder u_key_decoder (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .ev_valid    (ev_valid),
        .ev_data     (ev_data),
        .press_count (press_count)
    );

    event_queue u_event_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (ev_valid),
        .push_data (ev_data),
        .pop       (key_read),
        .ready     (key_ready),
        .head      (head),
        .overflow  (overflow)
    );

    // Head event fields
    assign key_release = head[EVENT_W-1];
    assign key_code    = head[15:8];
    assign key_ascii   = head[7:0];

endmodule

`default_nettype wire

//--- verif/keyboard_assert.sv
`default_nettype none

module keyboard_assert import kbd_pkg::*; (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 key_ready,
    input wire logic                 overflow,
    input wire logic [QUEUE_PTR_W:0] occupancy
);

    // Queue comes out of reset empty
    ready_low_after_reset: assert property (@(posedge clk) reset |=> !key_ready)
        else $error("key_ready high on the cycle after reset");

    // Sticky flag
    overflow_sticky: assert property (@(posedge clk)
        (!reset && !$past(reset)) |-> !$fell(overflow))
        else $error("overflow fell without reset");

    occupancy_bound: assert property (@(posedge clk)
        occupancy <= (QUEUE_PTR_W + 1)'(QUEUE_DEPTH))
        else $error("queue occupancy above depth");

endmodule

bind keyboard_top keyboard_assert u_keyboard_assert (
    .clk       (clk),
    .reset     (reset),
    .key_ready (key_ready),
    .overflow  (overflow),
    .occupancy (u_event_queue.occupancy)
);

`default_nettype wire

//--- verif/tb_keyboard.sv
`default_nettype none

module tb_keyboard import kbd_pkg::*; ();

    localparam int HALF_BIT      = 10;   // System cycles per PS/2 clock phase
    localparam int FRAME_GAP     = 20;   // Idle cycles between frames
    localparam int READY_TIMEOUT = 400;

    logic       clk = 1'b0;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    logic       key_read;
    logic       key_ready;
    logic [7:0] key_code;
    logic [7:0] key_ascii;
    logic       key_release;
    logic [7:0] press_count;
    logic       overflow;
    logic       frame_error;

    logic [EVENT_W-1:0] expected_q[$];   // Events the DUT queue should hold
    logic [7:0]         exp_press = 8'd0;
    logic               exp_frame_error = 1'b0;
    logic               exp_overflow = 1'b0;
    logic               pend_break = 1'b0;
    logic               host_reading = 1'b1;
    int                 check_count = 0;
    int                 error_count = 0;
    int                 timeout_count = 0;

    always #10 clk = ~clk;

    keyboard_top u_keyboard_top (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key_read    (key_read),
        .key_ready   (key_ready),
        .key_code    (key_code),
        .key_ascii   (key_ascii),
        .key_release (key_release),
        .press_count (press_count),
        .overflow    (overflow),
        .frame_error (frame_error)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Start, data LSB first, parity, stop
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [FRAME_BITS-1:0] bits;
        logic                  parity;
        int                    i;
        parity = ~^code;                 // Odd parity
        if (bad_parity)
            parity = ~parity;
        bits = {1'b1, parity, code, 1'b0};
        for (i = 0; i < FRAME_BITS; i++) begin
            ps2_data = bits[i];          // Changes while ps2_clk is high
            wait_cycles(HALF_BIT / 2);
            ps2_clk = 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk = 1'b1;
            wait_cycles(HALF_BIT / 2);
        end
        ps2_data = 1'b1;
        wait_cycles(FRAME_GAP);
    endtask

    task automatic wait_key_ready(output logic ok);
        int cycles;
        cycles = 0;
        while (!key_ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = key_ready;
        if (!ok) begin
            $display("Timeout: key_ready did not rise within %0d cycles", READY_TIMEOUT);
            timeout_count++;
        end
    endtask

    // Pops every expected event and compares the head fields
    task automatic drain_queue();
        logic [EVENT_W-1:0] exp_ev;
        logic               ok;
        while (expected_q.size() > 0) begin
            exp_ev = expected_q.pop_front();
            wait_key_ready(ok);
            if (!ok) begin
                expected_q.delete();
                break;
            end
            check_value(key_release, exp_ev[16], "key_release");
            check_value(key_code, exp_ev[15:8], "key_code");
            check_value(key_ascii, exp_ev[7:0], "key_ascii");
            key_read = 1'b1;             // One-cycle strobe
            @(negedge clk);
            key_read = 1'b0;
        end
        check_value(key_ready, 1'b0, "key_ready after drain");
    endtask

    task automatic check_status();
        check_value(press_count, exp_press, "press_count");
        check_value(frame_error, exp_frame_error, "frame_error");
        check_value(overflow, exp_overflow, "overflow");
    endtask

    task automatic apply_frame(input logic [7:0] code, input logic bad,
                               input logic [7:0] ascii);
        if (bad) begin
            exp_frame_error = 1'b1;      // Frame is dropped
        end else if (code == BREAK_CODE) begin
            pend_break = 1'b1;
        end else begin
            if (!pend_break)
                exp_press = exp_press + 8'd1;
            if (expected_q.size() == QUEUE_DEPTH)
                exp_overflow = 1'b1;     // Full queue drops it
            else
                expected_q.push_back({pend_break, code, ascii});
            pend_break = 1'b0;
        end
        send_frame(code, bad);
        if (host_reading) begin
            drain_queue();
        end else begin
            check_value(key_ready, expected_q.size() > 0, "key_ready while holding");
        end
        check_status();
    endtask

    task automatic run_trace();
        int                fd;
        int                n;
        string             kind;
        logic [8*128-1:0]  rest;
        logic [7:0]        code;
        logic [7:0]        bad;
        logic [7:0]        ascii;
        fd = $fopen("verif/keyboard_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verif/keyboard_trace.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1)
                break;
            if (kind == "#") begin
                n = $fgets(rest, fd);    // Skip comment text
            end else if (kind == "F") begin
                n = $fscanf(fd, "%h %h %h", code, bad, ascii);
                if (n != 3) begin
                    $display("Malformed frame line in the trace file");
                    error_count++;
                    break;
                end
                apply_frame(code, bad[0], ascii);
            end else if (kind == "R") begin
                drain_queue();
                check_status();
                host_reading = 1'b1;
            end else if (kind == "H") begin
                host_reading = 1'b0;
            end else begin
                $display("Unknown line type %s in the trace file", kind);
                error_count++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        reset    = 1'b1;
        ps2_clk  = 1'b1;                 // Lines idle high
        ps2_data = 1'b1;
        key_read = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value(key_ready, 1'b0, "key_ready after reset");
        check_status();
        run_trace();
        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/keyboard_trace.txt
# F code bad_parity ascii : one frame, all values hex, ascii is the expected head field
# R : host drains the queue and keeps reading ; H : host stops reading
F 1C 0 41
F 32 0 42
F 45 0 30
F 16 0 31
F 0D 0 00
F 5A 0 00
F F0 0 00
F 1C 0 41
F 21 1 43
F 21 0 43
H
F 24 0 45
F 2B 0 46
F 34 0 47
F 33 0 48
F 43 0 49
F 3B 0 4A
F 42 0 4B
F 4B 0 4C
F 3A 0 4D
R
F 3E 0 38
F F0 0 00
F 3E 0 38
F 46 0 39

//--- flist.f
verilog/kbd_pkg.sv
verilog/ps2_rx.sv
verilog/key_decoder.sv
verilog/event_queue.sv
verilog/keyboard_top.sv
verif/keyboard_assert.sv
verif/tb_keyboard.sv

//--- Bender.yml
package:
  name: ps2_keyboard

sources:
  - verilog/kbd_pkg.sv
  - verilog/ps2_rx.sv
  - verilog/key_decoder.sv
  - verilog/event_queue.sv
  - verilog/keyboard_top.sv
  - target: test
    files:
      - verif/keyboard_assert.sv
      - verif/tb_keyboard.sv
